// File: design/clock_reset_top.sv
`timescale 1ns/1ps

module clock_reset_top (
    input  logic       sys_clockb,
    input  logic       internal_rst,
    input  logic       is_pal,
    input  logic       pll_locked,
    output logic       rst,
    output logic [1:0] chip,
    output logic       dot_stb,
    output logic       col_stb
);

    // sequencer to timer handshake
    timer_if timer_bus ();

    // filtered PLL lock level
    logic lock_stable;
    // one-shot strap sample request
    logic std_latch;

    startup_timer startup_timer_inst (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .tmr          (timer_bus.tmr)
    );

    pll_lock_filter pll_lock_filter_inst (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .pll_locked   (pll_locked),
        .lock_stable  (lock_stable)
    );

    reset_sequencer reset_sequencer_inst (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .lock_stable  (lock_stable),
        .tmr          (timer_bus.seq),
        .rst          (rst),
        .std_latch    (std_latch)
    );

    // chip leaves here as a plain 2-bit code
    phase_strobe_gen phase_strobe_gen_inst (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .rst          (rst),
        .std_latch    (std_latch),
        .is_pal       (is_pal),
        .chip         (chip),
        .dot_stb      (dot_stb),
        .col_stb      (col_stb)
    );

endmodule

// File: design/phase_strobe_gen.sv
`timescale 1ns/1ps

`include "clkgen_defines.svh"

module phase_strobe_gen (
    input  logic                 sys_clockb,
    input  logic                 internal_rst,
    input  logic                 rst,
    input  logic                 std_latch,
    input  logic                 is_pal,
    output video_std_pkg::chip_e chip,
    output logic                 dot_stb,
    output logic                 col_stb
);
    import video_std_pkg::*;

    localparam int ACC_W = `PHASE_ACC_WIDTH;
    // channel 0 is the dot strobe, channel 1 the color strobe
    localparam int NCH   = 2;

    logic [ACC_W-1:0] inc    [NCH];
    logic [ACC_W-1:0] acc    [NCH];
    // extra top bit is the wrap
    logic [ACC_W:0]   sum    [NCH];
    logic [NCH-1:0]   wrap_q;

    // strap sampled once when the sequencer says so
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            chip <= CHIP6567R8;
        end else if (std_latch) begin
            chip <= is_pal ? CHIP6569 : CHIP6567R8;
        end
    end

    // increments follow the latched standard
    always_comb begin
        if (chip == CHIP6569) begin
            inc[0] = ACC_W'(`DOT_INC_PAL);
            inc[1] = ACC_W'(`COL_INC_PAL);
        end else begin
            inc[0] = ACC_W'(`DOT_INC_NTSC);
            inc[1] = ACC_W'(`COL_INC_NTSC);
        end
    end

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            sum[i] = {1'b0, acc[i]} + {1'b0, inc[i]};
        end
    end

    // accumulators sit at zero for the whole video reset
    always_ff @(posedge sys_clockb) begin
        for (int i = 0; i < NCH; i++) begin
            if (internal_rst || rst) begin
                acc[i]    <= '0;
                wrap_q[i] <= 1'b0;
            end else begin
                acc[i]    <= sum[i][ACC_W-1:0];
                wrap_q[i] <= sum[i][ACC_W];
            end
        end
    end

    // rst mask covers the first cycle of a new video reset
    // when wrap_q still holds the last running sample
    assign dot_stb = wrap_q[0] & ~rst;
    assign col_stb = wrap_q[1] & ~rst;

    // strobe registers are empty once video reset has been seen for a cycle
    a_no_stb_in_rst: assert property (@(posedge sys_clockb) disable iff (internal_rst)
        (rst && $past(rst)) |-> (wrap_q == '0));

endmodule

// File: design/pll_lock_filter.sv
`timescale 1ns/1ps

`include "clkgen_defines.svh"

module pll_lock_filter (
    input  logic sys_clockb,
    input  logic internal_rst,
    input  logic pll_locked,
    output logic lock_stable
);

    localparam int FILT_LEN = `LOCK_FILTER_CYCLES;
    localparam int FILT_W   = $clog2(FILT_LEN + 1);

    // raw lock comes straight from the PLL pin
    logic              locked_q;
    logic [FILT_W-1:0] run_cnt;

    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            locked_q    <= 1'b0;
            run_cnt     <= '0;
            lock_stable <= 1'b0;
        end else begin
            locked_q <= pll_locked;
            if (!locked_q) begin
                // any dropout starts the run over
                run_cnt     <= '0;
                lock_stable <= 1'b0;
            end else if (run_cnt != FILT_W'(FILT_LEN)) begin
                run_cnt     <= run_cnt + 1'b1;
                // goes high with the last sample of the run
                lock_stable <= (run_cnt == FILT_W'(FILT_LEN - 1));
            end else begin
                // saturated, lock stays good
                lock_stable <= 1'b1;
            end
        end
    end

endmodule

// File: design/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
    input  logic  sys_clockb,
    input  logic  internal_rst,
    input  logic  lock_stable,
    timer_if.seq  tmr,
    output logic  rst,
    output logic  std_latch
);
    import rst_seq_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;
    // remembers that the standard was already latched since internal_rst
    logic       latched_seen;

    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_HOLD: begin
                // hold ends regardless of lock, WAIT_LOCK sorts that out
                if (tmr.expired) begin
                    state_nxt = SEQ_WAIT_LOCK;
                end
            end
            SEQ_WAIT_LOCK: begin
                if (lock_stable) begin
                    state_nxt = SEQ_SYNC;
                end
            end
            SEQ_SYNC: begin
                if (!lock_stable) begin
                    state_nxt = SEQ_WAIT_LOCK;
                end else if (tmr.expired) begin
                    state_nxt = SEQ_RUN;
                end
            end
            SEQ_RUN: begin
                // lost lock drops video back into reset
                if (!lock_stable) begin
                    state_nxt = SEQ_WAIT_LOCK;
                end
            end
            default: begin
                state_nxt = SEQ_HOLD;
            end
        endcase
    end

    // strap is sampled once, right as the power-up hold runs out
    assign std_latch = (state == SEQ_HOLD) && tmr.expired;

    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            state        <= SEQ_HOLD;
            // hold timer request sits ready for the first cycle out of reset
            tmr.start    <= 1'b1;
            tmr.sel      <= TMR_HOLD;
            rst          <= 1'b1;
            latched_seen <= 1'b0;
        end else begin
            state     <= state_nxt;
            // start goes out together with the entry into SYNC
            tmr.start <= (state_nxt == SEQ_SYNC) && (state != SEQ_SYNC);
            // every start after the power-up hold is a sync start
            tmr.sel   <= TMR_SYNC;
            // registered from next state so rst tracks state exactly
            rst       <= (state_nxt != SEQ_RUN);
            if (std_latch) begin
                latched_seen <= 1'b1;
            end
        end
    end

    // a missing lock always puts video into reset on the next cycle
    a_rst_on_lock_loss: assert property (@(posedge sys_clockb) disable iff (internal_rst)
        !lock_stable |=> rst);

    // standard is latched at most once per internal_rst
    a_std_latch_once: assert property (@(posedge sys_clockb) disable iff (internal_rst)
        std_latch |-> !latched_seen);

endmodule

// File: design/rst_seq_pkg.sv
package rst_seq_pkg;

    // reset sequencer states in the order they are normally walked
    typedef enum logic [1:0] {
        SEQ_HOLD      = 2'd0,
        SEQ_WAIT_LOCK = 2'd1,
        SEQ_SYNC      = 2'd2,
        SEQ_RUN       = 2'd3
    } seq_state_e;

    // which length the startup timer loads on start
    typedef enum logic {
        TMR_HOLD = 1'b0,
        TMR_SYNC = 1'b1
    } timer_sel_e;

endpackage

// File: design/startup_timer.sv
`timescale 1ns/1ps

`include "clkgen_defines.svh"

module startup_timer (
    input logic   sys_clockb,
    input logic   internal_rst,
    timer_if.tmr  tmr
);
    import rst_seq_pkg::*;

    localparam int HOLD_LEN = `RST_HOLD_CYCLES;
    localparam int SYNC_LEN = `SYNC_CYCLES;
    // counter only needs to hold the longer of the two lengths
    localparam int MAX_LEN  = (HOLD_LEN > SYNC_LEN) ? HOLD_LEN : SYNC_LEN;
    localparam int CNT_W    = $clog2(MAX_LEN + 1);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] load_val;

    // load one less so expired lands exactly LEN cycles after start
    always_comb begin
        if (tmr.sel == TMR_HOLD) begin
            load_val = CNT_W'(HOLD_LEN - 1);
        end else begin
            load_val = CNT_W'(SYNC_LEN - 1);
        end
    end

    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            count       <= '0;
            tmr.busy    <= 1'b0;
            tmr.expired <= 1'b0;
        end else begin
            tmr.expired <= 1'b0;
            // a start while busy simply reloads
            if (tmr.start) begin
                count    <= load_val;
                tmr.busy <= 1'b1;
            end else if (tmr.busy) begin
                if (count <= CNT_W'(1)) begin
                    count       <= '0;
                    tmr.busy    <= 1'b0;
                    tmr.expired <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // expiry only ever closes a running count
    a_expired_after_busy: assert property (@(posedge sys_clockb) disable iff (internal_rst)
        tmr.expired |-> $past(tmr.busy));

endmodule

// File: design/timer_if.sv
`timescale 1ns/1ps

interface timer_if;
    import rst_seq_pkg::*;

    // one-cycle request to (re)load the timer
    logic       start;
    // length select, only looked at together with start
    timer_sel_e sel;
    // high from the cycle after start until expiry
    logic       busy;
    // single-cycle pulse as busy drops
    logic       expired;

    // sequencer side
    modport seq (
        output start,
        output sel,
        input  busy,
        input  expired
    );

    // timer side
    modport tmr (
        input  start,
        input  sel,
        output busy,
        output expired
    );

endinterface

// File: design/video_std_pkg.sv
package video_std_pkg;

    // video chip standard as carried on the chip output
    // encoding matches the old hard-coded chip values
    // codes 2 and 3 are reserved for other revisions
    typedef enum logic [1:0] {
        CHIP6567R8 = 2'd0,
        CHIP6569   = 2'd1
    } chip_e;

endpackage

// File: include/clkgen_defines.svh
`ifndef CLKGEN_DEFINES_SVH
`define CLKGEN_DEFINES_SVH

// power-up hold in sys_clockb cycles
// short stand-in for the ~150 ms hold of the board build
`define RST_HOLD_CYCLES 40

// consecutive registered lock samples before the PLL counts as stable
// must stay below RST_HOLD_CYCLES
`define LOCK_FILTER_CYCLES 8

// length of the synchronizing phase, one per flop of the old 2-flop chain
`define SYNC_CYCLES 2

// phase accumulator width shared by dot and color channels
`define PHASE_ACC_WIDTH 16

// per-standard phase increments
// increment = f_out / f_sys * 65536 with sys_clockb taken as 100 MHz
// 4x dot clock 31.527 MHz on 6569 PAL
`define DOT_INC_PAL 16'd20661
// 4x dot clock 32.727 MHz on 6567R8 NTSC
`define DOT_INC_NTSC 16'd21448
// 4x color clock 17.734 MHz on PAL
`define COL_INC_PAL 16'd11622
// 4x color clock 14.318 MHz on NTSC
`define COL_INC_NTSC 16'd9383

`endif

// File: project.f
+incdir+include
design/video_std_pkg.sv
design/rst_seq_pkg.sv
design/timer_if.sv
design/startup_timer.sv
design/pll_lock_filter.sv
design/reset_sequencer.sv
design/phase_strobe_gen.sv
design/clock_reset_top.sv
tests/clock_reset_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the clock and reset testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG" build.log

verilator --binary --timing --assert --top-module clock_reset_tb \
    -f project.f -o clock_reset_sim > build.log 2>&1 \
    && ./obj_dir/clock_reset_sim > "$LOG" 2>&1 \
    || echo "build or simulation did not complete, see build.log and $LOG"

[ -f "$LOG" ] && cat "$LOG"

grep -qx "SIMULATION PASSED" "$LOG" 2>/dev/null && echo "result: pass" && exit 0 \
    || { echo "result: fail"; exit 1; }

// File: tests/clock_reset_stimulus.txt
# is_pal lock_delay glitch_at glitch_len run_cycles exp_chip
# cycles count from internal_rst release, glitch_at 0 means no glitch, exp_chip 1 = 6569
1 0 0 0 400 1
0 0 0 0 400 0
1 0 0 0 1000 1
1 20 0 0 200 1
0 36 0 0 250 0
1 60 0 0 300 1
0 75 0 0 300 0
1 10 20 6 300 1
0 50 54 5 300 0
1 45 48 3 250 1
0 0 80 4 300 0
1 0 100 1 300 1
0 0 120 12 200 0
1 0 200 7 150 1

// File: tests/clock_reset_tb.sv
`timescale 1ns/1ps

`include "clkgen_defines.svh"

module clock_reset_tb;

    localparam int HOLD       = `RST_HOLD_CYCLES;
    localparam int FILT       = `LOCK_FILTER_CYCLES;
    localparam int SYNC       = `SYNC_CYCLES;
    localparam int ACC_W      = `PHASE_ACC_WIDTH;
    // upper bound for any single wait, in cycles
    localparam int WAIT_LIMIT = 2000;
    // extra cases with a random late lock
    localparam int N_RANDOM   = 2;

    logic       sys_clockb;
    logic       internal_rst;
    logic       is_pal;
    logic       pll_locked;
    logic       rst;
    logic [1:0] chip;
    logic       dot_stb;
    logic       col_stb;

    // case being run
    int case_pal;
    int lock_delay;
    int glitch_at;
    int glitch_len;
    int run_cycles;
    int exp_chip;

    // falling edges since internal_rst dropped
    int     cyc;
    int     errors;
    int     case_errors;
    int     cases_run;
    int     cases_failed;
    integer seed;

    clock_reset_top clock_reset_top_inst (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .is_pal       (is_pal),
        .pll_locked   (pll_locked),
        .rst          (rst),
        .chip         (chip),
        .dot_stb      (dot_stb),
        .col_stb      (col_stb)
    );

    // 4 ns period
    always #2 sys_clockb = ~sys_clockb;

    // lock level for a given cycle, low before lock_delay and inside the glitch
    function automatic logic lock_level(input int c);
        logic in_glitch;
        in_glitch = (glitch_at != 0) && (c >= glitch_at) && (c < glitch_at + glitch_len);
        return (c >= lock_delay) && !in_glitch;
    endfunction

    task automatic report_value(input string name, input int exp_v, input int act_v);
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        case_errors++;
    endtask

    task automatic report_range(input string name, input int lo, input int hi, input int act_v);
        $display("FAILED at %0t: %s expected %0d..%0d, got %0d", $time, name, lo, hi, act_v);
        case_errors++;
    endtask

    task automatic report_text(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        case_errors++;
    endtask

    // one cycle: sample outputs, then drive lock for the new cycle
    task automatic step_cycle;
        @(negedge sys_clockb);
        cyc++;
        // strobes only with video out of reset
        if (rst && dot_stb) begin
            report_value("dot_stb", 0, int'(dot_stb));
        end
        if (rst && col_stb) begin
            report_value("col_stb", 0, int'(col_stb));
        end
        pll_locked = lock_level(cyc);
    endtask

    // 2 cycles of internal_rst, cycle 0 starts at the falling edge that drops it
    task automatic apply_reset;
        @(negedge sys_clockb);
        internal_rst = 1'b1;
        is_pal       = (case_pal != 0);
        pll_locked   = lock_level(0);
        repeat (2) @(negedge sys_clockb);
        internal_rst = 1'b0;
        cyc          = 0;
        if (rst !== 1'b1) begin
            report_value("rst", 1, int'(rst));
        end
        if (dot_stb !== 1'b0 || col_stb !== 1'b0) begin
            report_text("strobe active right after internal_rst");
        end
        if (int'(chip) != 0) begin
            report_value("chip", 0, int'(chip));
        end
    endtask

    // counted wait for rst to read low
    task automatic wait_release(output int rel, output bit ok);
        int i;
        ok  = 1'b0;
        rel = 0;
        for (i = 0; i < WAIT_LIMIT && !ok; i++) begin
            step_cycle();
            if (!rst) begin
                ok  = 1'b1;
                rel = cyc;
            end
        end
    endtask

    task automatic run_case;
        int rel;
        int rel2;
        int eff_rise;
        int lo;
        int dot_cnt;
        int col_cnt;
        int dot_exp;
        int col_exp;
        int i;
        bit ok;
        bit go;
        bit seen_high;
        case_errors = 0;
        go          = 1'b0;
        apply_reset();
        wait_release(rel, ok);
        if (!ok) begin
            report_text("rst was never released after internal_rst");
        end else begin
            go = 1'b1;
            // a glitch before release restarts the filter from its end
            if (glitch_at != 0 && glitch_at < rel) begin
                eff_rise = glitch_at + glitch_len;
            end else begin
                eff_rise = lock_delay;
            end
            // lock already stable when the hold ends
            if (eff_rise <= HOLD - FILT) begin
                if (rel != HOLD + SYNC + 3) begin
                    report_value("rst release cycle", HOLD + SYNC + 3, rel);
                end
            end else begin
                lo = eff_rise + FILT;
                if (rel < lo || rel > lo + SYNC + 4) begin
                    report_range("rst release cycle", lo, lo + SYNC + 4, rel);
                end
            end
            if (int'(chip) != exp_chip) begin
                report_value("chip", exp_chip, int'(chip));
            end
        end
        // glitch while running
        if (go && glitch_at != 0 && glitch_at >= rel) begin
            go = 1'b0;
            i  = 0;
            while (cyc < glitch_at && i < WAIT_LIMIT) begin
                step_cycle();
                i++;
            end
            if (cyc < glitch_at) begin
                report_text("timed out walking to the lock glitch");
            end else begin
                seen_high = 1'b0;
                for (i = 0; i < 3 && !seen_high; i++) begin
                    step_cycle();
                    seen_high = rst;
                end
                if (!seen_high) begin
                    report_text("rst did not rise within 3 cycles of the lock glitch");
                end else begin
                    wait_release(rel2, ok);
                    if (!ok) begin
                        report_text("rst was never released after the lock glitch");
                    end else begin
                        go = 1'b1;
                        lo = glitch_at + glitch_len + FILT;
                        if (rel2 < lo || rel2 > lo + SYNC + 4) begin
                            report_range("rst re-release cycle", lo, lo + SYNC + 4, rel2);
                        end
                    end
                end
            end
        end
        // strobe counts over the run window from a cleared accumulator
        if (go) begin
            dot_cnt = 0;
            col_cnt = 0;
            for (i = 0; i < run_cycles && go; i++) begin
                if (rst) begin
                    report_text("rst rose inside the strobe counting window");
                    go = 1'b0;
                end else begin
                    dot_cnt = dot_cnt + int'(dot_stb);
                    col_cnt = col_cnt + int'(col_stb);
                    step_cycle();
                end
            end
            if (exp_chip == 1) begin
                dot_exp = int'((longint'(run_cycles) * int'(`DOT_INC_PAL)) >> ACC_W);
                col_exp = int'((longint'(run_cycles) * int'(`COL_INC_PAL)) >> ACC_W);
            end else begin
                dot_exp = int'((longint'(run_cycles) * int'(`DOT_INC_NTSC)) >> ACC_W);
                col_exp = int'((longint'(run_cycles) * int'(`COL_INC_NTSC)) >> ACC_W);
            end
            if (go && (dot_cnt < dot_exp - 1 || dot_cnt > dot_exp + 1)) begin
                report_range("dot_stb count", dot_exp - 1, dot_exp + 1, dot_cnt);
            end
            if (go && (col_cnt < col_exp - 1 || col_cnt > col_exp + 1)) begin
                report_range("col_stb count", col_exp - 1, col_exp + 1, col_cnt);
            end
        end
        cases_run++;
        errors = errors + case_errors;
        if (case_errors != 0) begin
            cases_failed++;
        end
        $display("case %0d: is_pal=%0d lock_delay=%0d glitch=%0d/%0d run=%0d: %s",
                 cases_run, case_pal, lock_delay, glitch_at, glitch_len, run_cycles,
                 (case_errors == 0) ? "pass" : "fail");
    endtask

    initial begin
        int    fd;
        int    n;
        int    k;
        string line;
        sys_clockb   = 1'b0;
        internal_rst = 1'b1;
        is_pal       = 1'b0;
        pll_locked   = 1'b0;
        errors       = 0;
        cases_run    = 0;
        cases_failed = 0;
        cyc          = 0;
        seed         = 32'ha692;
        fd = $fopen("tests/clock_reset_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file tests/clock_reset_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not scan
                n = $sscanf(line, "%d %d %d %d %d %d", case_pal, lock_delay, glitch_at,
                            glitch_len, run_cycles, exp_chip);
                if (n == 6) begin
                    run_case();
                end
            end
            $fclose(fd);
            if (cases_run == 0) begin
                $display("ERROR: the stimulus file held no test cases");
                errors++;
            end
        end
        // late lock somewhere past the hold
        for (k = 0; k < N_RANDOM; k++) begin
            case_pal   = $random(seed) & 1;
            lock_delay = HOLD + ($random(seed) & 31);
            glitch_at  = 0;
            glitch_len = 0;
            run_cycles = 200;
            exp_chip   = case_pal;
            run_case();
        end
        $display("cases run %0d, cases failed %0d, errors %0d", cases_run, cases_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
